/* mem_pkg.sv */
//////////////////////////////////////////////////
// Main memory definitions
// Word and address types, geometry and read latency
// of the pipelined word memory
//////////////////////////////////////////////////

package mem_pkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////

   // Data word width
   localparam int WORD_BITS = 16;

   // Byte address width
   localparam int ADDR_BITS = 16;

   //////////////////////////////////////////////////
   // Geometry and timing
   //////////////////////////////////////////////////

   // One word per even byte address
   localparam int MEM_WORDS = 2 ** (ADDR_BITS - 1);

   // Cycles from read issue to data_valid
   localparam int MEM_LATENCY = 4;

   // One data word
   typedef logic [WORD_BITS-1:0] word_t;

   // Byte address, bit 0 always zero
   typedef logic [ADDR_BITS-1:0] addr_t;

   // Word index into the memory array
   typedef logic [ADDR_BITS-2:0] word_addr_t;

endpackage

/* cache_pkg.sv */
//////////////////////////////////////////////////
// Cache definitions
// Address split, line geometry, field helpers and
// the controller state encoding
//////////////////////////////////////////////////

package cache_pkg;

   //////////////////////////////////////////////////
   // Address split
   //////////////////////////////////////////////////

   // Word within block, byte address bits 3..1
   localparam int OFFSET_BITS = 3;
   // Line select, bits 9..4
   localparam int INDEX_BITS = 6;
   // Remaining upper bits, 15..10
   localparam int TAG_BITS = 6;

   // Field positions in the byte address
   localparam int OFFSET_LSB = 1;
   localparam int INDEX_LSB = OFFSET_LSB + OFFSET_BITS;
   localparam int TAG_LSB = INDEX_LSB + INDEX_BITS;

   // Geometry
   localparam int LINES = 2 ** INDEX_BITS;
   localparam int BLOCK_WORDS = 2 ** OFFSET_BITS;

   typedef logic [OFFSET_BITS-1:0] offset_t;
   typedef logic [INDEX_BITS-1:0] index_t;
   typedef logic [TAG_BITS-1:0] tag_t;

   // Controller states
   typedef enum logic [1:0] {
      IDLE,
      FILL,
      UPDATE
   } cache_state_t;

   //////////////////////////////////////////////////
   // Field helpers
   //////////////////////////////////////////////////

   function automatic offset_t addr_offset(input mem_pkg::addr_t addr);
      return addr[INDEX_LSB-1:OFFSET_LSB];
   endfunction

   function automatic index_t addr_index(input mem_pkg::addr_t addr);
      return addr[TAG_LSB-1:INDEX_LSB];
   endfunction

   function automatic tag_t addr_tag(input mem_pkg::addr_t addr);
      return addr[TAG_LSB+TAG_BITS-1:TAG_LSB];
   endfunction

   // Same block, word replaced by the given offset
   function automatic mem_pkg::addr_t block_addr(input mem_pkg::addr_t addr,
                                                 input offset_t offset);
      return {addr[TAG_LSB+TAG_BITS-1:INDEX_LSB], offset, 1'b0};
   endfunction

endpackage

/* main_memory.sv */
//////////////////////////////////////////////////
// Main memory
// 16-bit word memory, single-cycle write and a
// four-stage read pipeline with a valid strobe
//////////////////////////////////////////////////

`timescale 1ns/1ps

module main_memory (
   input  logic            clk,
   input  logic            rst,
   input  logic            enable,
   input  logic            wr,
   input  mem_pkg::addr_t  addr,
   input  mem_pkg::word_t  data_in,
   output mem_pkg::word_t  data_out,
   output logic            data_valid
);

   // Word storage, undefined until written
   mem_pkg::word_t mem [mem_pkg::MEM_WORDS];

   // Read pipeline, stage 0 first
   mem_pkg::word_t pipe_data [mem_pkg::MEM_LATENCY];
   logic [mem_pkg::MEM_LATENCY-1:0] pipe_valid;

   mem_pkg::word_addr_t word_index;
   mem_pkg::word_t rd_word;
   logic rd_req;

   // Drop the byte bit
   assign word_index = addr[mem_pkg::ADDR_BITS-1:1];

   assign rd_req = enable && !wr;
   // Zero on idle cycles keeps the pipeline quiet
   assign rd_word = rd_req ? mem[word_index] : '0;

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (enable && wr) begin
         mem[word_index] <= data_in;
      end
   end

   //////////////////////////////////////////////////
   // Read pipeline
   //////////////////////////////////////////////////

   // One read may enter per cycle, up to four in flight
   always_ff @(posedge clk) begin
      if (rst) begin
         pipe_valid <= '0;
         for (int i = 0; i < mem_pkg::MEM_LATENCY; i++) begin
            pipe_data[i] <= '0;
         end
      end else begin
         pipe_valid <= {pipe_valid[mem_pkg::MEM_LATENCY-2:0], rd_req};
         pipe_data[0] <= rd_word;
         for (int i = 1; i < mem_pkg::MEM_LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
         end
      end
   end

   // Last stage drives the outputs
   assign data_out = pipe_data[mem_pkg::MEM_LATENCY-1];
   assign data_valid = pipe_valid[mem_pkg::MEM_LATENCY-1];

   // Word accesses only
   a_even_addr: assert property (@(posedge clk) disable iff (rst)
      enable |-> !addr[0]);

endmodule

/* tag_array.sv */
//////////////////////////////////////////////////
// Tag array
// Tag and valid bit per line, hit compare for the
// current processor address
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tag_array (
   input  logic            clk,
   input  logic            rst,
   input  mem_pkg::addr_t  addr,
   input  logic            fill_tag_we,
   output logic            hit
);

   // Stored tags, meaningful only under valid
   cache_pkg::tag_t tags [cache_pkg::LINES];
   logic [cache_pkg::LINES-1:0] valid;

   cache_pkg::index_t index;
   cache_pkg::tag_t tag;

   assign index = cache_pkg::addr_index(addr);
   assign tag = cache_pkg::addr_tag(addr);

   // Indexed line valid and tag equal
   assign hit = valid[index] && (tags[index] == tag);

   //////////////////////////////////////////////////
   // Valid bits
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else if (fill_tag_we) begin
         valid[index] <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Tag storage
   //////////////////////////////////////////////////

   // Written once the whole block is in
   always_ff @(posedge clk) begin
      if (fill_tag_we) begin
         tags[index] <= tag;
      end
   end

endmodule

/* data_array.sv */
//////////////////////////////////////////////////
// Data array
// Cache word storage, combinational read and one
// synchronous word write per cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module data_array (
   input  logic               clk,
   input  mem_pkg::addr_t     rd_addr,
   output mem_pkg::word_t     rd_data,
   input  logic               we,
   input  cache_pkg::index_t  wr_index,
   input  cache_pkg::offset_t wr_offset,
   input  mem_pkg::word_t     wr_data
);

   localparam int DEPTH = cache_pkg::LINES * cache_pkg::BLOCK_WORDS;

   // Flat storage, line index above word offset
   mem_pkg::word_t words [DEPTH];

   cache_pkg::index_t rd_index;
   cache_pkg::offset_t rd_offset;

   assign rd_index = cache_pkg::addr_index(rd_addr);
   assign rd_offset = cache_pkg::addr_offset(rd_addr);

   // Read for hits, same cycle as the request
   assign rd_data = words[{rd_index, rd_offset}];

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   // Write hit word or returning fill word
   always_ff @(posedge clk) begin
      if (we) begin
         words[{wr_index, wr_offset}] <= wr_data;
      end
   end

endmodule

/* fill_counter.sv */
//////////////////////////////////////////////////
// Fill counters
// Issue and return word counters that sequence
// one eight-word block fill
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fill_counter (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  logic               issue,
   input  logic               returned,
   output cache_pkg::offset_t issue_offset,
   output cache_pkg::offset_t fill_offset,
   output logic               issue_last,
   output logic               fill_last
);

   localparam cache_pkg::offset_t LAST = cache_pkg::offset_t'(cache_pkg::BLOCK_WORDS - 1);

   assign issue_last = (issue_offset == LAST);
   assign fill_last = (fill_offset == LAST);

   // Both hold at the last word until the next start
   always_ff @(posedge clk) begin
      if (rst || start) begin
         issue_offset <= '0;
         fill_offset <= '0;
      end else begin
         if (issue && !issue_last) begin
            issue_offset <= issue_offset + 1'b1;
         end
         if (returned && !fill_last) begin
            fill_offset <= fill_offset + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   // No step past the last word within one fill
   a_issue_no_wrap: assert property (@(posedge clk) disable iff (rst)
      issue && issue_last |=> !issue until start);
   a_fill_no_wrap: assert property (@(posedge clk) disable iff (rst)
      returned && fill_last |=> !returned until start);

   // Memory returns trail the issued reads
   a_return_after_issue: assert property (@(posedge clk) disable iff (rst)
      returned |-> (fill_offset < issue_offset) || (fill_last && issue_last));

endmodule

/* cache_fsm.sv */
//////////////////////////////////////////////////
// Cache controller
// Serves read hits and write-through writes, runs
// read misses as pipelined eight-word block fills
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cache_fsm (
   input  logic clk,
   input  logic rst,
   input  logic cpu_rd,
   input  logic cpu_wr,
   input  logic hit,
   input  logic issue_last,
   input  logic fill_last,
   input  logic returned,
   output logic done,
   output logic stall,
   output logic mem_enable,
   output logic mem_wr,
   output logic fill_start,
   output logic issue,
   output logic filling,
   output logic fill_tag_we,
   output logic cache_wr
);

   cache_pkg::cache_state_t state;
   cache_pkg::cache_state_t next_state;

   // Set once the eighth read is out
   logic issue_done;

   //////////////////////////////////////////////////
   // State registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= cache_pkg::IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_ff @(posedge clk) begin
      if (rst || fill_start) begin
         issue_done <= 1'b0;
      end else if (issue && issue_last) begin
         issue_done <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Next state and outputs
   //////////////////////////////////////////////////

   always_comb begin
      next_state = state;
      done = 1'b0;
      stall = 1'b0;
      mem_enable = 1'b0;
      mem_wr = 1'b0;
      fill_start = 1'b0;
      issue = 1'b0;
      filling = 1'b0;
      fill_tag_we = 1'b0;
      cache_wr = 1'b0;
      case (state)
         cache_pkg::IDLE: begin
            if (cpu_wr) begin
               // Write-through, no allocate on a miss
               done = 1'b1;
               mem_enable = 1'b1;
               mem_wr = 1'b1;
               cache_wr = hit;
            end else if (cpu_rd && hit) begin
               done = 1'b1;
            end else if (cpu_rd) begin
               // Miss, counters cleared for the fill
               stall = 1'b1;
               fill_start = 1'b1;
               next_state = cache_pkg::FILL;
            end
         end
         cache_pkg::FILL: begin
            stall = 1'b1;
            filling = 1'b1;
            // One read per cycle until all eight are out
            issue = !issue_done;
            mem_enable = issue;
            if (returned && fill_last) begin
               next_state = cache_pkg::UPDATE;
            end
         end
         cache_pkg::UPDATE: begin
            // Block complete, mark line valid
            stall = 1'b1;
            fill_tag_we = 1'b1;
            next_state = cache_pkg::IDLE;
         end
         default: begin
            next_state = cache_pkg::IDLE;
         end
      endcase
   end

   // Processor drives one request at a time
   a_one_request: assert property (@(posedge clk) disable iff (rst)
      !(cpu_rd && cpu_wr));

endmodule

/* cache_top.sv */
//////////////////////////////////////////////////
// Cache top level
// Direct-mapped write-through cache in front of
// the pipelined main memory
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cache_top (
   input  logic           clk,
   input  logic           rst,
   input  mem_pkg::addr_t cpu_addr,
   input  mem_pkg::word_t cpu_wdata,
   input  logic           cpu_rd,
   input  logic           cpu_wr,
   output mem_pkg::word_t cpu_rdata,
   output logic           done,
   output logic           stall
);

   // Controller strobes
   logic hit;
   logic mem_enable;
   logic mem_wr;
   logic fill_start;
   logic issue;
   logic filling;
   logic fill_tag_we;
   logic cache_wr;

   // Fill sequencing
   cache_pkg::offset_t issue_offset;
   cache_pkg::offset_t fill_offset;
   logic issue_last;
   logic fill_last;

   // Memory side
   mem_pkg::addr_t mem_addr;
   mem_pkg::word_t mem_rdata;
   logic data_valid;

   // Data array write port
   logic arr_we;
   cache_pkg::offset_t arr_offset;
   mem_pkg::word_t arr_wdata;

   //////////////////////////////////////////////////
   // Fill or processor selects
   //////////////////////////////////////////////////

   assign mem_addr = filling ? cache_pkg::block_addr(cpu_addr, issue_offset) : cpu_addr;
   assign arr_we = filling ? data_valid : cache_wr;
   assign arr_offset = filling ? fill_offset : cache_pkg::addr_offset(cpu_addr);
   assign arr_wdata = filling ? mem_rdata : cpu_wdata;

   cache_fsm fsm_i (
      .clk(clk), .rst(rst), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .hit(hit),
      .issue_last(issue_last), .fill_last(fill_last), .returned(data_valid),
      .done(done), .stall(stall), .mem_enable(mem_enable), .mem_wr(mem_wr),
      .fill_start(fill_start), .issue(issue), .filling(filling),
      .fill_tag_we(fill_tag_we), .cache_wr(cache_wr)
   );

   fill_counter counter_i (
      .clk(clk), .rst(rst), .start(fill_start), .issue(issue),
      .returned(data_valid), .issue_offset(issue_offset),
      .fill_offset(fill_offset), .issue_last(issue_last), .fill_last(fill_last)
   );

   tag_array tags_i (
      .clk(clk), .rst(rst), .addr(cpu_addr), .fill_tag_we(fill_tag_we), .hit(hit)
   );

   // Index always from the held processor address
   data_array data_i (
      .clk(clk), .rd_addr(cpu_addr), .rd_data(cpu_rdata), .we(arr_we),
      .wr_index(cache_pkg::addr_index(cpu_addr)), .wr_offset(arr_offset),
      .wr_data(arr_wdata)
   );

   main_memory mem_i (
      .clk(clk), .rst(rst), .enable(mem_enable), .wr(mem_wr), .addr(mem_addr),
      .data_in(cpu_wdata), .data_out(mem_rdata), .data_valid(data_valid)
   );

endmodule

/* tb_cache.sv */
//////////////////////////////////////////////////
// Cache testbench
// Directed tests of the write-through cache with
// memory and tag reference models
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cache;

   // Read miss to done, request cycle excluded
   localparam int MISS_CYCLES = 14;
   localparam int DONE_LIMIT = 20;
   // Requests over all tests, rounded up
   localparam int NUM_REQUESTS = 260;
   localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 20 + 200;

   logic clk;
   logic rst;
   mem_pkg::addr_t cpu_addr;
   mem_pkg::word_t cpu_wdata;
   logic cpu_rd;
   logic cpu_wr;
   mem_pkg::word_t cpu_rdata;
   logic done;
   logic stall;

   // Reference models
   mem_pkg::word_t mem_model [mem_pkg::word_addr_t];
   logic line_valid [cache_pkg::LINES];
   logic [5:0] line_tag [cache_pkg::LINES];
   string test_name;

   cache_top dut_i (
      .clk(clk), .rst(rst), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
      .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_rdata(cpu_rdata), .done(done),
      .stall(stall)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Errors found");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   //////////////////////////////////////////////////
   // One request, held until done
   //////////////////////////////////////////////////

   task automatic access(input bit is_wr, input mem_pkg::addr_t addr,
                         input mem_pkg::word_t wdata);
      int idx;
      bit hit_exp;
      int exp_cycles;
      int cycles;
      mem_pkg::word_t exp_data;
      // Line and tag straight from address bits 9..4 and 15..10
      idx = addr[9:4];
      hit_exp = line_valid[idx] && (line_tag[idx] == addr[15:10]);
      exp_cycles = (is_wr || hit_exp) ? 0 : MISS_CYCLES;
      @(posedge clk);
      cpu_addr <= addr;
      cpu_wdata <= wdata;
      cpu_rd <= !is_wr;
      cpu_wr <= is_wr;
      cycles = 0;
      // Request cycle
      @(negedge clk);
      assert (stall == (exp_cycles != 0)) else
         abort_run($sformatf("FAILED %s: stall at %h expected %0b actual %0b",
                             test_name, addr, exp_cycles != 0, stall));
      while (!done && cycles < DONE_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      assert (done) else
         abort_run($sformatf("No done from the cache in %s for address %h", test_name, addr));
      assert (cycles == exp_cycles) else
         abort_run($sformatf("FAILED %s: latency at %h expected %0d actual %0d",
                             test_name, addr, exp_cycles, cycles));
      assert (!stall) else
         abort_run($sformatf("Stall still high with done in %s at %h", test_name, addr));
      if (is_wr) begin
         mem_model[addr[15:1]] = wdata;
      end else begin
         exp_data = mem_model[addr[15:1]];
         assert (cpu_rdata === exp_data) else
            abort_run($sformatf("FAILED %s: data at %h expected %h actual %h",
                                test_name, addr, exp_data, cpu_rdata));
         // A read miss leaves the block cached
         line_valid[idx] = 1'b1;
         line_tag[idx] = addr[15:10];
      end
      @(posedge clk);
      cpu_rd <= 1'b0;
      cpu_wr <= 1'b0;
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic write_then_read();
      mem_pkg::addr_t addrs [4];
      test_name = "write_then_read";
      addrs = '{16'h0012, 16'h0124, 16'h0a36, 16'h3f4e};
      foreach (addrs[i]) access(1'b1, addrs[i], mem_pkg::word_t'($urandom));
      foreach (addrs[i]) access(1'b0, addrs[i], '0);
   endtask

   task automatic block_fill();
      test_name = "block_fill";
      for (int i = 0; i < 8; i++) access(1'b1, 16'h2040 + 2 * i, mem_pkg::word_t'($urandom));
      // Middle word misses, then the whole block hits
      access(1'b0, 16'h2046, '0);
      for (int i = 0; i < 8; i++) access(1'b0, 16'h2040 + 2 * i, '0);
   endtask

   task automatic conflict_eviction();
      test_name = "conflict_eviction";
      // Same line 5, tags 1 and 2
      access(1'b1, 16'h0450, 16'ha5a5);
      access(1'b1, 16'h0850, 16'h5a5a);
      for (int i = 0; i < 3; i++) begin
         access(1'b0, 16'h0450, '0);
         access(1'b0, 16'h0850, '0);
      end
   endtask

   task automatic write_hit_miss();
      test_name = "write_hit_miss";
      // Line 5 holds the 0850 block here
      access(1'b1, 16'h0850, 16'h1234);
      access(1'b0, 16'h0850, '0);
      access(1'b0, 16'h0450, '0);
      access(1'b0, 16'h0850, '0);
      // No allocate, so the read still misses
      access(1'b1, 16'h0450, 16'hbeef);
      access(1'b0, 16'h0450, '0);
   endtask

   task automatic random_mix();
      mem_pkg::addr_t addr;
      bit is_wr;
      test_name = "random_mix";
      for (int n = 0; n < 200; n++) begin
         // Tags 0..3, lines 0..3, any word
         addr = {4'b0, 2'($urandom), 4'b0, 2'($urandom), 3'($urandom), 1'b0};
         is_wr = $urandom_range(1, 0);
         // Unwritten words are undefined
         if (!mem_model.exists(addr[15:1])) is_wr = 1'b1;
         access(is_wr, addr, mem_pkg::word_t'($urandom));
      end
   endtask

   //////////////////////////////////////////////////
   // Watchdog and main sequence
   //////////////////////////////////////////////////

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      abort_run("Watchdog expired before the tests completed");
   end

   initial begin
      void'($urandom(32'h656a));
      rst = 1'b1;
      cpu_addr = '0;
      cpu_wdata = '0;
      cpu_rd = 1'b0;
      cpu_wr = 1'b0;
      foreach (line_valid[i]) line_valid[i] = 1'b0;
      foreach (line_tag[i]) line_tag[i] = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      write_then_read();
      block_fill();
      conflict_eviction();
      write_hit_miss();
      random_mix();
      repeat (2) @(posedge clk);
      $display("No errors");
      $finish;
   end

endmodule

/* sources.f */
mem_pkg.sv
cache_pkg.sv
main_memory.sv
tag_array.sv
data_array.sv
fill_counter.sv
cache_fsm.sv
cache_top.sv
tb_cache.sv
